//--- noc_router_arb.f
+incdir+source
source/noc_port_pkg.sv
source/noc_flit_pkg.sv
source/noc_route_stage.sv
source/rr_output_arbiter.sv
source/output_credit_counter.sv
source/switch_allocator.sv
source/router_arbiter.sv
bench/router_arbiter_tb.sv

//--- Bender.yml
package:
  name: noc_router_arb

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/noc_port_pkg.sv
      - source/noc_flit_pkg.sv
      - source/noc_route_stage.sv
      - source/rr_output_arbiter.sv
      - source/output_credit_counter.sv
      - source/switch_allocator.sv
      - source/router_arbiter.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/router_arbiter_tb.sv

//--- bench/router_arbiter_tb.sv
//############################
// random traffic bench for the
// router switch allocator.
//############################
`timescale 1ns/100ps
`include "noc_config.svh"

module router_arbiter_tb
	import noc_port_pkg::*;
	import noc_flit_pkg::*;
();

	localparam int P          = `NOC_PORTS;
	localparam int PKT        = `NOC_PKT_FLITS;
	localparam int CLK_PERIOD = 8;
	localparam int RUN_CYCLES = 2000;
	localparam int MARGIN     = 200;
	localparam int HOME       = 5; // router sits at (5,5).

	logic           clk;
	logic           rst_n_i;
	logic [7:0]     router_xy_i;
	noc_flit_u      ib_flit [P];
	noc_port_vec_t  ib_valid_i;
	noc_port_vec_t  credit_return_i;
	noc_port_vec_t  ib_read_o;
	noc_port_vec_t  out_valid_o;
	wire [3*P-1:0]  src_flat; // out_src of all outputs, north lowest.

	// buffer and next router models.
	logic [31:0]    rng;
	noc_flit_u      nxt_flit [P];
	noc_port_vec_t  nxt_valid;
	noc_port_vec_t  nxt_ret;
	int             pkt_pos [P];   // flits of the front packet popped.
	int             pkt_route [P]; // output of the front packet.
	int             held [P];      // slots taken downstream.

	// reference model state.
	int             rs_busy [P];
	int             rs_route [P];
	int             rs_cnt [P];
	int             ar_busy [P];
	int             ar_owner [P];
	int             ar_ptr [P];
	int             credits [P];

	// scoreboard.
	int             sent [P];
	int             returned [P];
	int             run_len [P];
	int             last_src [P];
	int             checks [5];
	int             errors [5];
	int             cycle;
	int             first_valid;
	string          test_name [5] = '{"reset", "routing", "packets", "round robin", "credits"};
	string          src_name [5] = '{"out_src_n_o", "out_src_s_o", "out_src_w_o",
		"out_src_e_o", "out_src_l_o"};

	router_arbiter uut (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.router_xy_i     (router_xy_i),
		.ib_flit_n_i     (ib_flit[PORT_N]),
		.ib_flit_s_i     (ib_flit[PORT_S]),
		.ib_flit_w_i     (ib_flit[PORT_W]),
		.ib_flit_e_i     (ib_flit[PORT_E]),
		.ib_flit_l_i     (ib_flit[PORT_L]),
		.ib_valid_i      (ib_valid_i),
		.credit_return_i (credit_return_i),
		.ib_read_o       (ib_read_o),
		.out_valid_o     (out_valid_o),
		.out_src_n_o     (src_flat[2:0]),
		.out_src_s_o     (src_flat[5:3]),
		.out_src_w_o     (src_flat[8:6]),
		.out_src_e_o     (src_flat[11:9]),
		.out_src_l_o     (src_flat[14:12])
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int rand_below(input int n);
		rng = xorshift(rng);
		return int'(rng % n);
	endfunction

	// y first, a larger y is north, a larger x is east.
	function automatic int yx_port(input noc_flit_u f);
		if (f.hdr.dst_y > HOME)
			return PORT_N;
		if (f.hdr.dst_y < HOME)
			return PORT_S;
		if (f.hdr.dst_x > HOME)
			return PORT_E;
		if (f.hdr.dst_x < HOME)
			return PORT_W;
		return PORT_L;
	endfunction

	// next front flit of buffer p.
	task automatic make_flit(input int p);
		if (pkt_pos[p] == 0) begin
			nxt_flit[p].hdr.dst_y = 4'(rand_below(16));
			nxt_flit[p].hdr.dst_x = 4'(rand_below(16));
			nxt_flit[p].hdr.src_y = 4'(HOME);
			nxt_flit[p].hdr.src_x = 4'(HOME);
			pkt_route[p] = yx_port(nxt_flit[p]);
		end else begin
			nxt_flit[p].body = 16'(rand_below(65536)); // body word.
		end
	endtask

	task automatic report_error(input int t, input string msg);
		errors[t]++;
		$display("%s", msg);
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin : main
		int total_chk;
		int total_err;
		total_chk       = 0;
		total_err       = 0;
		rng             = 32'd57384;
		rst_n_i         = 1'b0;
		router_xy_i     = 8'h55; // {y, x}.
		ib_valid_i      = '0;
		credit_return_i = '0;
		nxt_valid       = '0;
		nxt_ret         = '0;
		cycle           = 0;
		first_valid     = -1;
		for (int p = 0; p < P; p++) begin
			credits[p]  = `NOC_CREDITS;
			last_src[p] = -1;
			make_flit(p);
			ib_flit[p]  = nxt_flit[p];
		end
		repeat (3) @(posedge clk);
		rst_n_i <= 1'b1;
		repeat (RUN_CYCLES) @(posedge clk);
		for (int t = 0; t < 5; t++) begin
			$display("test %0d %s: %0d checks, %0d errors",
				t + 1, test_name[t], checks[t], errors[t]);
			total_chk += checks[t];
			total_err += errors[t];
		end
		$display("all tests: %0d checks, %0d errors in %0d cycles", total_chk, total_err, cycle);
		if (total_err == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial begin
		#((3 + RUN_CYCLES + MARGIN) * CLK_PERIOD);
		$display("watchdog expired before the run ended");
		$display("Test FAILED");
		$finish;
	end

	// inputs change only on the rising edge.
	always @(posedge clk) begin
		ib_valid_i      <= nxt_valid;
		credit_return_i <= nxt_ret;
		for (int p = 0; p < P; p++)
			ib_flit[p] <= nxt_flit[p];
	end

	// compare on the falling edge, then step the model to the next rising edge.
	always @(negedge clk) begin : check_and_model
		noc_port_vec_t exp_send;
		noc_port_vec_t exp_read;
		int            s;
		int            w;
		if (rst_n_i) begin
			cycle++;
			exp_send = '0;
			exp_read = '0;
			for (int o = 0; o < P; o++) begin
				if (ar_busy[o] && ib_valid_i[ar_owner[o]] && credits[o] > 0) begin
					exp_send[o]           = 1'b1;
					exp_read[ar_owner[o]] = 1'b1;
				end
			end
			checks[0]++;
			if (cycle == 1 && (ib_read_o !== '0 || out_valid_o !== '0))
				report_error(0, $sformatf(
					"Error: ib_read_o = 0x%h, out_valid_o = 0x%h, expected 0x00",
					ib_read_o, out_valid_o));
			if (out_valid_o != '0 && (first_valid < 0 || cycle < first_valid + 2))
				report_error(0, "a flit was sent less than 2 cycles after the first head");
			if (first_valid < 0 && ib_valid_i != '0)
				first_valid = cycle;
			checks[3]++;
			if (out_valid_o !== exp_send)
				report_error(3, $sformatf("Error: out_valid_o = 0x%h, expected 0x%h", out_valid_o, exp_send));
			if (ib_read_o !== exp_read)
				report_error(3, $sformatf("Error: ib_read_o = 0x%h, expected 0x%h", ib_read_o, exp_read));
			for (int p = 0; p < P; p++) begin
				checks[2]++;
				if (ib_read_o[p] && !ib_valid_i[p])
					report_error(2, $sformatf("input %0d was popped while its valid flag was low", p));
			end
			for (int o = 0; o < P; o++) begin
				if (out_valid_o[o]) begin
					s = src_flat[3*o +: 3];
					checks[1]++;
					if (pkt_route[s] != o)
						report_error(1, $sformatf("Error: %s = 0x%h, packet routes to 0x%h",
							src_name[o], s, pkt_route[s]));
					if (!ib_read_o[s])
						report_error(1, $sformatf("Error: ib_read_o = 0x%h, source 0x%h not popped",
							ib_read_o, s));
					checks[2]++;
					if (s != last_src[o] && run_len[o] % PKT != 0)
						report_error(2, $sformatf("output %0d changed source after %0d flits", o, run_len[o]));
					if (s != last_src[o])
						run_len[o] = 0;
					last_src[o] = s;
					run_len[o]++;
					checks[3]++;
					if (s != ar_owner[o])
						report_error(3, $sformatf("Error: %s = 0x%h, expected 0x%h",
							src_name[o], s, ar_owner[o]));
					checks[4]++;
					if (sent[o] >= `NOC_CREDITS + returned[o])
						report_error(4, $sformatf("output %0d sent with every credit in use", o));
					sent[o]++;
					held[o]++;
				end
				if (credit_return_i[o])
					returned[o]++;
			end
			// arbiters see the requests registered so far.
			for (int o = 0; o < P; o++) begin
				if (!ar_busy[o]) begin
					for (int i = 0; i < P; i++) begin
						w = (ar_ptr[o] + i) % P;
						if (!ar_busy[o] && rs_busy[w] && rs_route[w] == o) begin
							ar_busy[o]  = 1;
							ar_owner[o] = w;
							ar_ptr[o]   = (w + 1) % P;
						end
					end
				end else if (exp_send[o] && rs_cnt[ar_owner[o]] == PKT - 1) begin
					ar_busy[o] = 0; // tail leaves.
				end
				if (credit_return_i[o])
					credits[o]++;
				if (exp_send[o])
					credits[o]--;
			end
			for (int p = 0; p < P; p++) begin
				if (!rs_busy[p] && ib_valid_i[p]) begin
					rs_busy[p]  = 1;
					rs_route[p] = yx_port(ib_flit[p]);
				end else if (rs_busy[p] && exp_read[p]) begin
					rs_cnt[p]  = (rs_cnt[p] + 1) % PKT;
					rs_busy[p] = (rs_cnt[p] != 0);
				end
				// buffer shows its next flit after a pop, maybe after a gap.
				if (ib_read_o[p]) begin
					pkt_pos[p] = (pkt_pos[p] + 1) % PKT;
					make_flit(p);
					nxt_valid[p] = (rand_below(4) != 0);
				end else if (!nxt_valid[p]) begin
					nxt_valid[p] = (rand_below(2) == 0);
				end
			end
			for (int o = 0; o < P; o++) begin
				nxt_ret[o] = (held[o] > 0 && rand_below(4) == 0); // random delay.
				if (nxt_ret[o])
					held[o]--;
			end
		end
	end

endmodule

//--- source/router_arbiter.sv
//############################
// switch allocation top of the
// five-port mesh router.
//############################
`timescale 1ns/100ps
`include "noc_config.svh"

module router_arbiter
	import noc_port_pkg::*;
	import noc_flit_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic [2*`NOC_COORD_W-1:0] router_xy_i, // {y, x}.
	input  noc_flit_u                 ib_flit_n_i,
	input  noc_flit_u                 ib_flit_s_i,
	input  noc_flit_u                 ib_flit_w_i,
	input  noc_flit_u                 ib_flit_e_i,
	input  noc_flit_u                 ib_flit_l_i,
	input  noc_port_vec_t             ib_valid_i,
	input  noc_port_vec_t             credit_return_i,
	output noc_port_vec_t             ib_read_o,
	output noc_port_vec_t             out_valid_o,
	output logic [2:0]                out_src_n_o,
	output logic [2:0]                out_src_s_o,
	output logic [2:0]                out_src_w_o,
	output logic [2:0]                out_src_e_o,
	output logic [2:0]                out_src_l_o
);

	noc_flit_u     flit [`NOC_PORTS];
	noc_port_vec_t req [`NOC_PORTS]; // wanted output per input.
	noc_port_vec_t last_flit;

	assign flit[PORT_N] = ib_flit_n_i;
	assign flit[PORT_S] = ib_flit_s_i;
	assign flit[PORT_W] = ib_flit_w_i;
	assign flit[PORT_E] = ib_flit_e_i;
	assign flit[PORT_L] = ib_flit_l_i;

	for (genvar p = 0; p < `NOC_PORTS; p++) begin : g_in
		noc_route_stage u_rs (
			.clk         (clk),
			.rst_n_i     (rst_n_i),
			.router_xy_i (router_xy_i),
			.ib_flit_i   (flit[p]),
			.ib_valid_i  (ib_valid_i[p]),
			.ib_read_i   (ib_read_o[p]),
			.req_o       (req[p]),
			.last_flit_o (last_flit[p])
		);
	end

	switch_allocator u_sa (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.req_n_i         (req[PORT_N]),
		.req_s_i         (req[PORT_S]),
		.req_w_i         (req[PORT_W]),
		.req_e_i         (req[PORT_E]),
		.req_l_i         (req[PORT_L]),
		.last_flit_i     (last_flit),
		.ib_valid_i      (ib_valid_i),
		.credit_return_i (credit_return_i),
		.ib_read_o       (ib_read_o),
		.out_valid_o     (out_valid_o),
		.out_src_n_o     (out_src_n_o),
		.out_src_s_o     (out_src_s_o),
		.out_src_w_o     (out_src_w_o),
		.out_src_e_o     (out_src_e_o),
		.out_src_l_o     (out_src_l_o)
	);

endmodule

//--- source/switch_allocator.sv
//############################
// output arbiters, credits and
// pop strobes of the router.
//############################
`timescale 1ns/100ps
`include "noc_config.svh"

module switch_allocator
	import noc_port_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n_i,
	input  noc_port_vec_t req_n_i,
	input  noc_port_vec_t req_s_i,
	input  noc_port_vec_t req_w_i,
	input  noc_port_vec_t req_e_i,
	input  noc_port_vec_t req_l_i,
	input  noc_port_vec_t last_flit_i,
	input  noc_port_vec_t ib_valid_i,
	input  noc_port_vec_t credit_return_i,
	output noc_port_vec_t ib_read_o,
	output noc_port_vec_t out_valid_o,
	output logic [2:0]    out_src_n_o,
	output logic [2:0]    out_src_s_o,
	output logic [2:0]    out_src_w_o,
	output logic [2:0]    out_src_e_o,
	output logic [2:0]    out_src_l_o
);

	noc_port_e     owner [`NOC_PORTS];
	noc_port_vec_t credit_ok;

	for (genvar o = 0; o < `NOC_PORTS; o++) begin : g_out
		noc_port_vec_t out_req; // inputs that want output o.

		assign out_req = {req_l_i[o], req_e_i[o], req_w_i[o], req_s_i[o], req_n_i[o]};

		rr_output_arbiter u_arb (
			.clk         (clk),
			.rst_n_i     (rst_n_i),
			.req_i       (out_req),
			.last_flit_i (last_flit_i),
			.ib_valid_i  (ib_valid_i),
			.credit_ok_i (credit_ok[o]),
			.send_o      (out_valid_o[o]),
			.owner_o     (owner[o])
		);

		output_credit_counter u_cc (
			.clk             (clk),
			.rst_n_i         (rst_n_i),
			.send_i          (out_valid_o[o]),
			.credit_return_i (credit_return_i[o]),
			.credit_ok_o     (credit_ok[o])
		);
	end

	// each send pops one flit from its owner.
	always_comb begin
		ib_read_o = '0;
		for (int o = 0; o < `NOC_PORTS; o++)
			if (out_valid_o[o])
				ib_read_o[owner[o]] = 1'b1;
	end

	assign out_src_n_o = owner[PORT_N];
	assign out_src_s_o = owner[PORT_S];
	assign out_src_w_o = owner[PORT_W];
	assign out_src_e_o = owner[PORT_E];
	assign out_src_l_o = owner[PORT_L];

endmodule

//--- source/output_credit_counter.sv
//############################
// free slots in the buffer of
// the next router.
//############################
`timescale 1ns/100ps
`include "noc_config.svh"

module output_credit_counter (
	input  logic clk,
	input  logic rst_n_i,
	input  logic send_i,
	input  logic credit_return_i,
	output logic credit_ok_o
);

	localparam int CNT_W = $clog2(`NOC_CREDITS + 1);

	logic [CNT_W-1:0] cnt_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cnt_q <= CNT_W'(`NOC_CREDITS); // downstream starts empty.
		end else begin
			case ({send_i, credit_return_i})
				2'b10:   cnt_q <= cnt_q - 1'b1;
				2'b01:   cnt_q <= cnt_q + 1'b1;
				default: cnt_q <= cnt_q; // both or none.
			endcase
		end
	end

	// send allowed only with a free slot.
	assign credit_ok_o = (cnt_q != '0);

endmodule

//--- source/rr_output_arbiter.sv
//############################
// round-robin arbiter for one
// output, held for a packet.
//############################
`timescale 1ns/100ps
`include "noc_config.svh"

module rr_output_arbiter
	import noc_port_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n_i,
	input  noc_port_vec_t req_i,
	input  noc_port_vec_t last_flit_i,
	input  noc_port_vec_t ib_valid_i,
	input  logic          credit_ok_i,
	output logic          send_o,
	output noc_port_e     owner_o
);

	logic      busy_q;
	noc_port_e owner_q;
	noc_port_e ptr_q; // first port to look at.
	noc_port_e winner;
	logic      found;
	logic [3:0] idx;

	// first requester at or after the pointer.
	always_comb begin
		found  = 1'b0;
		winner = ptr_q;
		idx    = '0;
		for (int i = 0; i < `NOC_PORTS; i++) begin
			idx = {1'b0, ptr_q} + 4'(i);
			if (idx >= 4'(`NOC_PORTS))
				idx = idx - 4'(`NOC_PORTS); // wrap around.
			if (!found && req_i[idx[2:0]]) begin
				found  = 1'b1;
				winner = noc_port_e'(idx[2:0]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			busy_q  <= 1'b0;
			owner_q <= PORT_N;
			ptr_q   <= PORT_N;
		end else if (!busy_q) begin
			if (found) begin
				busy_q  <= 1'b1;
				owner_q <= winner;
				// winner goes to the back of the queue.
				ptr_q   <= (winner == PORT_L) ? PORT_N : noc_port_e'(winner + 3'd1);
			end
		end else if (send_o && last_flit_i[owner_q]) begin
			busy_q <= 1'b0; // tail flit leaves now.
		end
	end

	// stalls on an empty buffer or no credit, grant kept.
	assign send_o  = busy_q && ib_valid_i[owner_q] && credit_ok_i;
	assign owner_o = owner_q;

endmodule

//--- source/noc_route_stage.sv
//############################
// YX route decode and packet
// tracker for one input.
//############################
`timescale 1ns/100ps
`include "noc_config.svh"

module noc_route_stage
	import noc_port_pkg::*;
	import noc_flit_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic [2*`NOC_COORD_W-1:0] router_xy_i, // {y, x}.
	input  noc_flit_u                 ib_flit_i,
	input  logic                      ib_valid_i,
	input  logic                      ib_read_i,
	output noc_port_vec_t             req_o,
	output logic                      last_flit_o
);

	localparam int CNT_W = $clog2(`NOC_PKT_FLITS);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`NOC_PKT_FLITS - 1);

	logic [`NOC_COORD_W-1:0] my_y;
	logic [`NOC_COORD_W-1:0] my_x;
	noc_port_vec_t           route_d;
	noc_port_vec_t           req_q;
	logic [CNT_W-1:0]        cnt_q; // flits popped so far.
	logic                    busy;

	assign my_y = router_xy_i[2*`NOC_COORD_W-1:`NOC_COORD_W];
	assign my_x = router_xy_i[`NOC_COORD_W-1:0];
	assign busy = |req_q;

	// y first, then x.
	always_comb begin
		route_d = '0;
		if (ib_flit_i.hdr.dst_y > my_y)
			route_d[PORT_N] = 1'b1;
		else if (ib_flit_i.hdr.dst_y < my_y)
			route_d[PORT_S] = 1'b1;
		else if (ib_flit_i.hdr.dst_x > my_x)
			route_d[PORT_E] = 1'b1;
		else if (ib_flit_i.hdr.dst_x < my_x)
			route_d[PORT_W] = 1'b1;
		else
			route_d[PORT_L] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			req_q <= '0;
			cnt_q <= '0;
		end else if (!busy) begin
			if (ib_valid_i)
				req_q <= route_d; // front flit is a head here.
		end else if (ib_read_i) begin
			if (cnt_q == LAST_CNT) begin
				req_q <= '0; // packet done.
				cnt_q <= '0;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	assign req_o       = req_q;
	assign last_flit_o = busy && (cnt_q == LAST_CNT);

endmodule

//--- source/noc_flit_pkg.sv
//############################
// flit word, read as header
// or as body.
//############################
`include "noc_config.svh"

package noc_flit_pkg;

	// only the first flit of a packet is a header.
	typedef union packed {
		struct packed {
			logic [`NOC_COORD_W-1:0] dst_y;
			logic [`NOC_COORD_W-1:0] dst_x;
			logic [`NOC_COORD_W-1:0] src_y;
			logic [`NOC_COORD_W-1:0] src_x;
		} hdr;
		logic [4*`NOC_COORD_W-1:0] body; // plain payload.
	} noc_flit_u;

endpackage

//--- source/noc_port_pkg.sv
//############################
// port numbering of the router.
//############################
`include "noc_config.svh"

package noc_port_pkg;

	// port number, also the round-robin order.
	typedef enum logic [2:0] {
		PORT_N = 3'd0,
		PORT_S = 3'd1,
		PORT_W = 3'd2,
		PORT_E = 3'd3,
		PORT_L = 3'd4
	} noc_port_e;

	// one bit per port, indexed by noc_port_e.
	typedef logic [`NOC_PORTS-1:0] noc_port_vec_t;

endpackage

//--- source/noc_config.svh
//############################
// router-wide constants for the
// mesh switch allocator.
//############################
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// north, south, west, east, local.
`define NOC_PORTS 5

// fixed packet length, head included.
`define NOC_PKT_FLITS 4

// buffer depth of the next router.
`define NOC_CREDITS 4

`define NOC_COORD_W 4 // bits per mesh coordinate.

`endif
